// ==== Bender.yml ====
# Bender manifest for the decode stage
package:
  name: decode_stage

dependencies: {}

sources:
  # Package and interface come first so later files can refer to them
  - source/decodePkg.sv
  - source/regPortIf.sv
  - source/regFile.sv
  - source/writePortSelect.sv
  - source/branchResolve.sv
  - source/decodeStage.sv

  - target: test
    files:
      - tests/decodeStageTb.sv

// ==== src.f ====
source/decodePkg.sv
source/regPortIf.sv
source/regFile.sv
source/writePortSelect.sv
source/branchResolve.sv
source/decodeStage.sv
tests/decodeStageTb.sv

// ==== tests/decodeStageTb.sv ====
/*
   Decode stage testbench
   Directed and random stimulus against a shadow register model, with a
   comparing process that checks both read ports and the PC select
*/
`timescale 1ns/1ps

module decodeStageTb;

   localparam int maxCycles = 2000;   // 16 reset, about 330 directed, 600 random, plus margin

   logic clk, rst, lbi, link, en, bFlag, jFlag, halt, pcSel;
   logic [15:0] instr, imm, writeback, pcNow, reg1Data, reg2Data;
   logic [2:0] writeRegAddr;

   logic [15:0] shadow [8];    // Expected register contents
   logic [2:0] jalHist;        // Bit 0 execute, bit 1 memory, bit 2 writeback
   logic [19:0] expWrite;      // Enable, address and data of the expected write
   logic [31:0] rnd;
   integer seed;
   int errorCount, checkCount, cycleCount;

   decodeStage dut_i (.clk(clk), .rst(rst), .instr(instr), .imm(imm), .writeback(writeback),
      .pcNow(pcNow), .writeRegAddr(writeRegAddr), .lbi(lbi), .link(link), .en(en),
      .bFlag(bFlag), .jFlag(jFlag), .halt(halt), .reg1Data(reg1Data), .reg2Data(reg2Data),
      .pcSel(pcSel));

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Opcode in the top five bits, then Rs and Rt
   function automatic logic [15:0] mkInstr(input logic [4:0] op, input logic [2:0] rs,
                                           input logic [2:0] rt);
      return {op, rs, rt, 5'b0};
   endfunction

   function automatic logic isJal(input logic [15:0] ins);
      return ins[15:12] == 4'b0011;   // 00110 and 00111
   endfunction

   // Branch class or bFlag, not halted, and condition taken or jFlag
   function automatic logic expectedPcSel(input logic [15:0] ins, input logic [15:0] rsVal,
                                          input logic bF, input logic jF, input logic hlt);
      logic taken;
      case (ins[12:11])
         2'b00: taken = (rsVal == 16'h0000);
         2'b01: taken = (rsVal != 16'h0000);
         2'b10: taken = rsVal[15];
         default: taken = !rsVal[15];
      endcase
      return (ins[15:13] == 3'b011 || bF) && !hlt && (taken || jF);
   endfunction

   // Returns enable, address and data packed as one vector
   function automatic logic [19:0] expectedWrite(input logic [15:0] ins, input logic lbiIn,
         input logic linkIn, input logic enIn, input logic [15:0] immIn,
         input logic [15:0] wbIn, input logic [15:0] pcIn, input logic [2:0] wAddr,
         input logic wbSlotJal);
      logic jal;
      logic [15:0] data;
      jal = isJal(ins);
      if (linkIn || jal) begin
         data = pcIn + 16'd2;   // Return address
      end else if (lbiIn) begin
         data = immIn;
      end else begin
         data = wbIn;
      end
      return {jal || (enIn && !wbSlotJal), jal ? 3'd7 : wAddr, data};
   endfunction

   // Shadow state moves at the same edge as the DUT
   always @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 8; i++) begin
            shadow[i] = 16'h0000;
         end
         jalHist = 3'b000;
      end else begin
         expWrite = expectedWrite(instr, lbi, link, en, imm, writeback, pcNow, writeRegAddr,
                                  jalHist[2]);
         if (expWrite[19]) begin
            shadow[expWrite[18:16]] = expWrite[15:0];
         end
         jalHist = {jalHist[1:0], isJal(instr)};
      end
   end

   // Compare 1 ns before each rising edge when everything has settled
   always begin
      @(negedge clk);
      #4;
      if (!rst) begin
         checkCount += 3;
         if (reg1Data !== shadow[instr[10:8]]) begin
            errorCount++;
            $display("MISMATCH at %0t: reg1Data expected %h got %h", $time,
                     shadow[instr[10:8]], reg1Data);
         end
         if (reg2Data !== shadow[instr[7:5]]) begin
            errorCount++;
            $display("MISMATCH at %0t: reg2Data expected %h got %h", $time,
                     shadow[instr[7:5]], reg2Data);
         end
         if (pcSel !== expectedPcSel(instr, shadow[instr[10:8]], bFlag, jFlag, halt)) begin
            errorCount++;
            $display("MISMATCH at %0t: pcSel expected %b got %b", $time,
                     expectedPcSel(instr, shadow[instr[10:8]], bFlag, jFlag, halt), pcSel);
         end
      end
   end

   initial begin
      while (cycleCount < maxCycles) begin
         @(posedge clk);
         cycleCount++;
      end
      $display("Run timed out after %0d cycles before the tests completed", maxCycles);
      $display("TB FAILED");
      $finish;
   end

   task automatic tick();
      @(negedge clk);
   endtask

   // Quiet inputs with a non-branch, non-jump instruction
   task automatic idle();
      instr = 16'h0000;
      {lbi, link, en, bFlag, jFlag, halt} = 6'b0;
      writeRegAddr = 3'd0;
   endtask

   task automatic writeReg(input logic [2:0] addr, input logic [15:0] data);
      en = 1'b1;
      writeRegAddr = addr;
      writeback = data;
      tick();
      en = 1'b0;
   endtask

   initial begin
      seed = 32'h7f055a93;
      errorCount = 0;
      checkCount = 0;
      cycleCount = 0;
      rst = 1'b1;
      imm = 16'h0000;
      writeback = 16'h0000;
      pcNow = 16'h0000;
      idle();
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Every register reads zero after reset
      for (int r = 0; r < 8; r++) begin
         instr = mkInstr(5'b00000, r[2:0], 3'(7 - r));
         tick();
      end

      // Writes with en high land and are read back through Rs and Rt
      for (int r = 0; r < 8; r++) begin
         writeReg(r[2:0], 16'hA5C3 ^ (16'h1111 * 16'(r)));
         instr = mkInstr(5'b00000, r[2:0], r[2:0]);
         tick();
      end
      for (int r = 0; r < 8; r++) begin   // Writes with en low are ignored
         writeRegAddr = r[2:0];
         writeback = 16'hDEAD;
         instr = mkInstr(5'b00000, r[2:0], r[2:0]);
         tick();
      end

      // Load immediate, then link over load immediate
      lbi = 1'b1;
      imm = 16'hFF80;
      writeReg(3'd3, 16'h0BAD);
      link = 1'b1;
      pcNow = 16'h1234;
      writeReg(3'd4, 16'h0BAD);
      {lbi, link} = 2'b00;
      instr = mkInstr(5'b00000, 3'd3, 3'd4);
      tick();

      // JAL then JALR, each with writes one, two and three cycles later
      for (int j = 0; j < 2; j++) begin
         instr = mkInstr(5'b00110 | j[4:0], 3'd0, 3'd0);
         pcNow = 16'h0400 + 16'(j * 16'h100);
         writeReg(3'd2, 16'hBEEF);   // Overridden by the link write to R7
         idle();
         writeReg(3'd5, 16'h1001 + 16'(j));
         writeReg(3'd6, 16'h2002 + 16'(j));
         writeReg(3'd1, 16'h3003 + 16'(j));   // Falls in the jump's writeback slot
         instr = mkInstr(5'b00000, 3'd7, 3'd5);
         tick();
         instr = mkInstr(5'b00000, 3'd6, 3'd1);
         tick();
         instr = mkInstr(5'b00000, 3'd2, 3'd0);   // R2 keeps its old value
         tick();
      end

      // Branch operands zero, positive, negative and 8000 hex
      writeReg(3'd1, 16'h0000);
      writeReg(3'd2, 16'h0123);
      writeReg(3'd3, 16'hFFF0);
      writeReg(3'd4, 16'h8000);
      for (int c = 0; c < 4; c++) begin
         for (int r = 1; r <= 4; r++) begin
            for (int k = 0; k < 16; k++) begin
               instr = mkInstr(k[3] ? {3'b011, c[1:0]} : {3'b100, c[1:0]}, r[2:0], 3'd0);
               {bFlag, jFlag, halt} = k[2:0];
               tick();
            end
         end
      end
      idle();

      // Random instructions and control, with jumps made more frequent
      for (int n = 0; n < 600; n++) begin
         rnd = $random(seed);
         instr = rnd[15:0];
         if (rnd[18:16] == 3'b000) instr[15:12] = 4'b0011;
         rnd = $random(seed);
         imm = rnd[15:0];
         writeback = rnd[31:16];
         rnd = $random(seed);
         pcNow = rnd[15:0];
         writeRegAddr = rnd[18:16];
         {lbi, link, en, bFlag, jFlag} = rnd[23:19];
         halt = (rnd[25:24] == 2'b00);
         tick();
      end
      idle();
      tick();

      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== source/decodeStage.sv ====
/*
   Decode stage top level
   Splits the instruction into its fields and joins the register file, the
   write port selection and the branch resolution
*/
`timescale 1ns/1ps

module decodeStage (
   input logic                               clk,
   input logic                               rst,
   input logic [decodePkg::dataWidth-1:0]    instr,
   input logic [decodePkg::dataWidth-1:0]    imm,
   input logic [decodePkg::dataWidth-1:0]    writeback,
   input logic [decodePkg::dataWidth-1:0]    pcNow,         // PC of the instruction in decode
   input logic [decodePkg::regAddrWidth-1:0] writeRegAddr,
   input logic                               lbi,
   input logic                               link,
   input logic                               en,
   input logic                               bFlag,
   input logic                               jFlag,
   input logic                               halt,
   output logic [decodePkg::dataWidth-1:0]   reg1Data,      // Rs contents
   output logic [decodePkg::dataWidth-1:0]   reg2Data,      // Rt contents
   output logic                              pcSel
);

   decodePkg::opcodeT                  opcode;
   decodePkg::branchCondT              cond;
   logic [decodePkg::regAddrWidth-1:0] rsAddr;
   logic [decodePkg::regAddrWidth-1:0] rtAddr;

   regPortIf rp ();

   // Instruction fields
   assign opcode = decodePkg::opcodeT'(instr[decodePkg::opcodeLsb +: decodePkg::opcodeWidth]);
   assign cond   = decodePkg::branchCondT'(instr[decodePkg::opcodeLsb +: decodePkg::condWidth]);
   assign rsAddr = instr[decodePkg::rsLsb +: decodePkg::regAddrWidth];
   assign rtAddr = instr[decodePkg::rtLsb +: decodePkg::regAddrWidth];

   // Read side of the register port
   assign rp.readAddr1 = rsAddr;
   assign rp.readAddr2 = rtAddr;
   assign reg1Data     = rp.readData1;
   assign reg2Data     = rp.readData2;

   regFile rfInst (
      .clk (clk),
      .rst (rst),
      .rf  (rp)
   );

   writePortSelect wpsInst (
      .clk          (clk),
      .rst          (rst),
      .lbi          (lbi),
      .link         (link),
      .en           (en),
      .opcode       (opcode),
      .imm          (imm),
      .writeback    (writeback),
      .pcNow        (pcNow),
      .writeRegAddr (writeRegAddr),
      .wr           (rp)
   );

   // Rs doubles as the value the branch tests
   branchResolve brInst (
      .opcode (opcode),
      .cond   (cond),
      .rsData (reg1Data),
      .bFlag  (bFlag),
      .jFlag  (jFlag),
      .halt   (halt),
      .pcSel  (pcSel)
   );

endmodule

// ==== source/branchResolve.sv ====
/*
   Branch resolution
   Tests Rs against zero and its sign and decides whether the next PC is the
   branch or jump target
*/
`timescale 1ns/1ps

module branchResolve (
   input decodePkg::opcodeT               opcode,
   input decodePkg::branchCondT           cond,
   input logic [decodePkg::dataWidth-1:0] rsData,   // First read operand
   input logic                            bFlag,    // Branch class forced from control
   input logic                            jFlag,    // Unconditional jump
   input logic                            halt,
   output logic                           pcSel
);

   logic [decodePkg::opcodeWidth-1:0] opBits;     // Raw opcode value
   logic                              isZero;
   logic                              isNeg;
   logic                              isBranch;
   logic                              taken;

   assign opBits = opcode;

   // Status of Rs
   assign isZero = (rsData == '0);
   assign isNeg  = rsData[decodePkg::dataWidth-1];   // Two's complement sign

   // Branch class is decided by the top three opcode bits alone
   assign isBranch = (opBits[decodePkg::opcodeWidth-1 -: 3] == decodePkg::branchClass);

   // Condition evaluation
   always_comb begin
      taken = 1'b0;
      case (cond)
         decodePkg::condEqZero: taken = isZero;
         decodePkg::condNeZero: taken = !isZero;
         decodePkg::condLtZero: taken = isNeg;     // 8000 hex counts as negative
         decodePkg::condGeZero: taken = !isNeg;
      endcase
   end

   // A jump rides the branch path so jFlag only matters when branch or bFlag is set
   assign pcSel = (isBranch || bFlag) && !halt && (taken || jFlag);

endmodule

// ==== source/writePortSelect.sv ====
/*
   Write port selection
   Picks address, data and enable for the register file write port and tracks
   jump and link instructions through execute, memory and writeback
*/
`timescale 1ns/1ps

module writePortSelect (
   input logic                               clk,
   input logic                               rst,
   input logic                               lbi,           // Load byte immediate
   input logic                               link,          // Link write from a later stage
   input logic                               en,            // Writeback port wants to write
   input decodePkg::opcodeT                  opcode,
   input logic [decodePkg::dataWidth-1:0]    imm,           // Already sign extended
   input logic [decodePkg::dataWidth-1:0]    writeback,
   input logic [decodePkg::dataWidth-1:0]    pcNow,
   input logic [decodePkg::regAddrWidth-1:0] writeRegAddr,
   regPortIf.writer                          wr
);

   logic                            jalNow;    // Jump and link sitting in decode
   logic                            exJal;     // Same instruction one stage later
   logic                            memJal;
   logic                            wbJal;     // Reaches writeback this cycle
   logic [decodePkg::dataWidth-1:0] linkAddr;

   // JAL and JALR both write a return address
   assign jalNow = (opcode == decodePkg::opJal) || (opcode == decodePkg::opJalr);

   // Follow each jump and link down the pipe
   // Its writeback slot has to stay quiet since the link write already happened in decode
   always_ff @(posedge clk) begin
      if (rst) begin
         exJal  <= 1'b0;
         memJal <= 1'b0;
         wbJal  <= 1'b0;
      end else begin
         exJal  <= jalNow;
         memJal <= exJal;
         wbJal  <= memJal;
      end
   end

   assign linkAddr = pcNow + decodePkg::pcStep;   // Return address

   // A jump and link claims R7 no matter what writeback asks for
   assign wr.writeAddr = jalNow ? decodePkg::linkReg : writeRegAddr;

   // Link beats load immediate which beats ordinary writeback
   always_comb begin
      if (link || jalNow) begin
         wr.writeData = linkAddr;
      end else if (lbi) begin
         wr.writeData = imm;
      end else begin
         wr.writeData = writeback;
      end
   end

   // Writeback is dropped only in the slot that belongs to an earlier jump and link
   assign wr.writeEn = jalNow || (en && !wbJal);

   // An enabled write must carry a fully known register index
   writeAddrValid: assert property (
      @(posedge clk) disable iff (rst)
      wr.writeEn |-> !$isunknown(wr.writeAddr)
   ) else $error("writePortSelect enabled write to bad address %b", wr.writeAddr);

   // The writeback flag lines up exactly three cycles behind decode
   jalTrackDepth: assert property (
      @(posedge clk) disable iff (rst)
      (!$past(rst, 1) && !$past(rst, 2) && !$past(rst, 3)) |-> (wbJal == $past(jalNow, 3))
   ) else $error("writePortSelect jump and link tracking out of step");

endmodule

// ==== source/regFile.sv ====
/*
   Register file for the decode stage
   Eight 16-bit registers with two asynchronous reads and one write per clock
   A write becomes visible on the read ports in the following cycle
*/
`timescale 1ns/1ps

module regFile (
   input logic     clk,
   input logic     rst,
   regPortIf.owner rf
);

   // Register storage
   logic [decodePkg::dataWidth-1:0] regs [decodePkg::numRegs];

   // Reads look straight into the array
   // There is no bypass so a write in this cycle shows up only after the edge
   assign rf.readData1 = regs[rf.readAddr1];   // Rs port
   assign rf.readData2 = regs[rf.readAddr2];   // Rt port

   // Single write port
   always_ff @(posedge clk) begin
      if (rst) begin
         // The whole file comes up zeroed
         for (int i = 0; i < decodePkg::numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (rf.writeEn) begin
         regs[rf.writeAddr] <= rf.writeData;   // Lands at this edge
      end
   end

   // An unknown index on an enabled write would corrupt an arbitrary register,
   // which no later read could trace back to its source
   writeAddrKnown: assert property (
      @(posedge clk) disable iff (rst)
      rf.writeEn |-> !$isunknown(rf.writeAddr)
   ) else $error("regFile write enabled with unknown address %b", rf.writeAddr);

endmodule

// ==== source/regPortIf.sv ====
/*
   Register file port bundle
   Two combinational read ports and one clocked write port
*/
`timescale 1ns/1ps

interface regPortIf;

   // Read side, address in and data back in the same cycle
   logic [decodePkg::regAddrWidth-1:0] readAddr1;
   logic [decodePkg::regAddrWidth-1:0] readAddr2;
   logic [decodePkg::dataWidth-1:0]    readData1;
   logic [decodePkg::dataWidth-1:0]    readData2;

   // Write side, sampled at the rising clock edge
   logic [decodePkg::regAddrWidth-1:0] writeAddr;
   logic [decodePkg::dataWidth-1:0]    writeData;
   logic                               writeEn;

   // The register file itself
   modport owner (input readAddr1, readAddr2, writeAddr, writeData, writeEn,
                  output readData1, readData2);

   // Write port selection only ever touches the write side
   modport writer (output writeAddr, writeData, writeEn);

   // Decode reads Rs and Rt through this view
   modport reader (output readAddr1, readAddr2, input readData1, readData2);

endinterface

// ==== source/decodePkg.sv ====
/*
   Decode stage shared definitions
   Datapath widths, register constants, instruction field positions and the
   opcode and branch condition encodings seen by the decode stage
*/
package decodePkg;

   // Datapath and register file geometry
   localparam int dataWidth    = 16;   // Register and datapath width
   localparam int regAddrWidth = 3;    // Eight registers need three index bits
   localparam int numRegs      = 8;
   localparam int opcodeWidth  = 5;    // Opcode sits in instr bits 15 to 11
   localparam int condWidth    = 2;    // Branch condition is the low two opcode bits

   // Instruction field positions, given as the low bit of each field
   localparam int opcodeLsb = 11;
   localparam int rsLsb     = 8;       // Rs occupies bits 10 to 8
   localparam int rtLsb     = 5;       // Rt occupies bits 7 to 5

   // Jump and link always deposits its return address in R7
   localparam logic [regAddrWidth-1:0] linkReg = 3'd7;

   // Instructions are two bytes wide so the link address is pcNow plus two
   localparam logic [dataWidth-1:0] pcStep = 16'd2;

   // Any opcode with these top three bits belongs to the branch class
   localparam logic [2:0] branchClass = 3'b011;

   // Opcodes this stage has to recognise
   // Other opcodes still pass through unchanged as raw values
   typedef enum logic [opcodeWidth-1:0] {
      opJal  = 5'b00110,   // Jump and link with a displacement
      opJalr = 5'b00111,   // Jump and link through Rs
      opBeqz = 5'b01100,   // Branch if Rs equals zero
      opBnez = 5'b01101,   // Branch if Rs is not zero
      opBltz = 5'b01110,   // Branch if Rs is negative
      opBgez = 5'b01111    // Branch if Rs is zero or positive
   } opcodeT;

   // Branch condition carried in instr bits 12 to 11
   typedef enum logic [condWidth-1:0] {
      condEqZero = 2'b00,
      condNeZero = 2'b01,
      condLtZero = 2'b10,
      condGeZero = 2'b11
   } branchCondT;

endpackage
